// ==== rtl/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// first fetch after reset
`define RV_RESET_PC 32'h0000_0000

// machine CSR addresses
`define RV_CSR_MSTATUS 12'h300
`define RV_CSR_MTVEC   12'h305
`define RV_CSR_MEPC    12'h341
`define RV_CSR_MCAUSE  12'h342

// mstatus bit positions
`define RV_MSTATUS_MIE  3
`define RV_MSTATUS_MPIE 7

// environment call from M-mode
`define RV_CAUSE_ECALL 32'd11

`endif

// ==== rtl/rvPkg.sv ====
`default_nettype none

package rvPkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFields;

    typedef struct packed {
        logic [19:0] upper; // imm[31:12] for U, scrambled for J
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFields;

    typedef union packed {
        rFields rType;
        uFields immType;
    } instrWord;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } aluOp;

    typedef enum logic [2:0] {LEN_BYTE, LEN_HALF, LEN_WORD, LEN_UBYTE, LEN_UHALF} memLen;
    typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_RC} csrOp;
    typedef enum logic [2:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR, PC_TRAP, PC_MRET} pcSel;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // writeback source select
    localparam logic [2:0] WB_ALU  = 3'd0;
    localparam logic [2:0] WB_LOAD = 3'd1;
    localparam logic [2:0] WB_PC4  = 3'd2;
    localparam logic [2:0] WB_CSR  = 3'd3;
    localparam logic [2:0] WB_IMM  = 3'd4;

endpackage

`default_nettype wire

// ==== rtl/instrDecode.sv ====
`default_nettype none

module instrDecode (
    input  rvPkg::instrWord instr,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [4:0]      rd,
    output logic [31:0]     imm,
    output rvPkg::aluOp     aluOp,
    output logic            aluSrcImm,
    output logic            aluSrcPc,
    output logic            regWrite,
    output logic [2:0]      wbSel,
    output logic            memWrite,
    output logic            memRead,
    output rvPkg::memLen    memLen,
    output rvPkg::csrOp     csrOp,
    output logic            csrUseImm,
    output logic [11:0]     csrAddr,
    output logic            isBranch,
    output logic            isJal,
    output logic            isJalr,
    output logic            isEcall,
    output logic            isMret,
    output logic            isEbreak,
    output logic            isIllegal
);
    import rvPkg::*;

    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] immI, immS, immB, immU, immJ, immZ;

    assign f7 = instr.rType.funct7;
    assign f3 = instr.rType.funct3;

    assign immI = {{20{f7[6]}}, f7, instr.rType.rs2};
    assign immS = {{20{f7[6]}}, f7, instr.rType.rd};
    assign immB = {{20{f7[6]}}, instr.rType.rd[0], f7[5:0], instr.rType.rd[4:1], 1'b0};
    assign immU = {instr.immType.upper, 12'b0};
    assign immJ = {{12{instr.immType.upper[19]}}, instr.immType.upper[7:0],
                   instr.immType.upper[8], instr.immType.upper[18:9], 1'b0};
    assign immZ = {27'b0, instr.rType.rs1}; // csr uimm

    assign rs1     = instr.rType.rs1;
    assign rs2     = instr.rType.rs2;
    assign rd      = instr.rType.rd;
    assign csrAddr = {f7, instr.rType.rs2};

    always_comb begin
        imm = 32'b0;
        aluOp = ALU_ADD;
        aluSrcImm = 1'b0;
        aluSrcPc = 1'b0;
        regWrite = 1'b0;
        wbSel = WB_ALU;
        memWrite = 1'b0;
        memRead = 1'b0;
        memLen = LEN_WORD;
        csrOp = CSR_NONE;
        csrUseImm = 1'b0;
        isBranch = 1'b0;
        isJal = 1'b0;
        isJalr = 1'b0;
        isEcall = 1'b0;
        isMret = 1'b0;
        isEbreak = 1'b0;
        isIllegal = 1'b0;

        case (instr.rType.opcode)
            OPC_LUI: begin
                imm = immU;
                regWrite = 1'b1;
                wbSel = WB_IMM;
            end
            OPC_AUIPC: begin
                imm = immU;
                aluSrcPc = 1'b1; // pc + imm
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
            end
            OPC_JAL: begin
                imm = immJ;
                isJal = 1'b1;
                regWrite = 1'b1;
                wbSel = WB_PC4;
            end
            OPC_JALR: begin
                imm = immI;
                aluSrcImm = 1'b1;
                isJalr = 1'b1;
                regWrite = 1'b1;
                wbSel = WB_PC4;
                isIllegal = (f3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm = immB;
                aluOp = ALU_SUB;
                isBranch = 1'b1;
                isIllegal = (f3 == 3'b010) || (f3 == 3'b011);
            end
            OPC_LOAD: begin
                imm = immI;
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
                memRead = 1'b1;
                wbSel = WB_LOAD;
                case (f3)
                    3'b000: memLen = LEN_BYTE;
                    3'b001: memLen = LEN_HALF;
                    3'b010: memLen = LEN_WORD;
                    3'b100: memLen = LEN_UBYTE;
                    3'b101: memLen = LEN_UHALF;
                    default: isIllegal = 1'b1;
                endcase
            end
            OPC_STORE: begin
                imm = immS;
                aluSrcImm = 1'b1;
                memWrite = 1'b1;
                case (f3)
                    3'b000: memLen = LEN_BYTE;
                    3'b001: memLen = LEN_HALF;
                    3'b010: memLen = LEN_WORD;
                    default: isIllegal = 1'b1;
                endcase
            end
            OPC_OPIMM: begin
                imm = immI;
                aluSrcImm = 1'b1;
                regWrite = 1'b1;
                case (f3)
                    3'b000: aluOp = ALU_ADD;
                    3'b010: aluOp = ALU_SLT;
                    3'b011: aluOp = ALU_SLTU;
                    3'b100: aluOp = ALU_XOR;
                    3'b110: aluOp = ALU_OR;
                    3'b111: aluOp = ALU_AND;
                    3'b001: begin
                        aluOp = ALU_SLL;
                        isIllegal = (f7 != 7'b0000000);
                    end
                    default: begin // shamt shares f7 with the sra flag
                        aluOp = f7[5] ? ALU_SRA : ALU_SRL;
                        isIllegal = (f7 != 7'b0000000) && (f7 != 7'b0100000);
                    end
                endcase
            end
            OPC_OP: begin
                regWrite = 1'b1;
                case ({f7, f3})
                    10'b0000000_000: aluOp = ALU_ADD;
                    10'b0100000_000: aluOp = ALU_SUB;
                    10'b0000000_001: aluOp = ALU_SLL;
                    10'b0000000_010: aluOp = ALU_SLT;
                    10'b0000000_011: aluOp = ALU_SLTU;
                    10'b0000000_100: aluOp = ALU_XOR;
                    10'b0000000_101: aluOp = ALU_SRL;
                    10'b0100000_101: aluOp = ALU_SRA;
                    10'b0000000_110: aluOp = ALU_OR;
                    10'b0000000_111: aluOp = ALU_AND;
                    default: isIllegal = 1'b1;
                endcase
            end
            OPC_SYSTEM: begin
                if (f3 == 3'b000) begin
                    case (instr)
                        32'h0000_0073: isEcall = 1'b1;
                        32'h0010_0073: isEbreak = 1'b1;
                        32'h3020_0073: isMret = 1'b1;
                        default: isIllegal = 1'b1;
                    endcase
                end else if (f3 == 3'b100) begin
                    isIllegal = 1'b1;
                end else begin
                    regWrite = 1'b1;
                    wbSel = WB_CSR;
                    imm = immZ;
                    csrUseImm = f3[2];
                    case (f3[1:0])
                        2'b01: csrOp = CSR_RW;
                        2'b10: csrOp = CSR_RS;
                        default: csrOp = CSR_RC;
                    endcase
                end
            end
            default: isIllegal = 1'b1;
        endcase

        // nothing of an illegal word may reach state
        if (isIllegal) begin
            regWrite = 1'b0;
            memWrite = 1'b0;
            memRead = 1'b0;
            csrOp = CSR_NONE;
            isBranch = 1'b0;
            isJalr = 1'b0;
        end
    end

    always_comb begin
        assert ($onehot0({isJal, isJalr, isBranch}))
            else $error("more than one control transfer decoded");
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata,
    input  logic        we,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0)
            regs[rd] <= wdata;
    end

    // x0 never stored
    assign rdata1 = (rs1 == 5'd0) ? 32'b0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'b0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`default_nettype none

module alu (
    input  rvPkg::aluOp op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [2:0]  funct3,
    output logic [31:0] result,
    output logic        branchTaken
);
    import rvPkg::*;

    logic [32:0] diff;
    logic        lt, ltu, eq;

    assign diff = {1'b0, a} - {1'b0, b};
    assign ltu  = diff[32]; // borrow out
    assign lt   = (a[31] ^ b[31]) ? a[31] : diff[31];
    assign eq   = (diff[31:0] == 32'b0);

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = diff[31:0];
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << b[4:0];
            ALU_SRL:  result = a >> b[4:0];
            ALU_SRA:  result = $signed(a) >>> b[4:0];
            ALU_SLT:  result = {31'b0, lt};
            ALU_SLTU: result = {31'b0, ltu};
            default:  result = 32'b0;
        endcase
    end

    // funct3[0] inverts beq/blt/bltu
    always_comb begin
        case (funct3[2:1])
            2'b00:   branchTaken = eq ^ funct3[0];
            2'b10:   branchTaken = lt ^ funct3[0];
            2'b11:   branchTaken = ltu ^ funct3[0];
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/lsUnit.sv ====
`default_nettype none

module lsUnit (
    input  rvPkg::memLen len,
    input  logic [1:0]   addrLow,
    input  logic         storeEn,
    input  logic         loadEn,
    input  logic [31:0]  storeData,
    input  logic [31:0]  rawLoad,
    output logic [3:0]   wstrb,
    output logic [31:0]  wdata,
    output logic [31:0]  loadData
);
    import rvPkg::*;

    logic [31:0] lane;

    always_comb begin
        wstrb = 4'b0000;
        wdata = storeData;
        case (len)
            LEN_BYTE: begin
                wdata = {4{storeData[7:0]}};
                wstrb = 4'b0001 << addrLow;
            end
            LEN_HALF: begin
                wdata = {2{storeData[15:0]}};
                wstrb = 4'b0011 << {addrLow[1], 1'b0};
            end
            default: wstrb = 4'b1111;
        endcase
        if (!storeEn)
            wstrb = 4'b0000;
    end

    assign lane = rawLoad >> {addrLow, 3'b000}; // addressed byte to bit 0

    always_comb begin
        case (len)
            LEN_BYTE:  loadData = {{24{lane[7]}}, lane[7:0]};
            LEN_HALF:  loadData = {{16{lane[15]}}, lane[15:0]};
            LEN_UBYTE: loadData = {24'b0, lane[7:0]};
            LEN_UHALF: loadData = {16'b0, lane[15:0]};
            default:   loadData = rawLoad;
        endcase
    end

    always_comb begin
        if (storeEn || loadEn) begin
            if (len == LEN_HALF || len == LEN_UHALF)
                assert (addrLow[0] == 1'b0) else $error("misaligned half access");
            if (len == LEN_WORD)
                assert (addrLow == 2'b00) else $error("misaligned word access");
        end
    end

endmodule

`default_nettype wire

// ==== rtl/csrFile.sv ====
`default_nettype none
`include "rv_settings.svh"

module csrFile (
    input  logic        clk,
    input  logic        rst,
    input  rvPkg::csrOp op,
    input  logic [11:0] addr,
    input  logic [31:0] wval,
    input  logic        trap,
    input  logic [31:0] trapPc,
    output logic [31:0] oldVal,
    output logic [31:0] mtvec,
    output logic [31:0] mepc
);
    import rvPkg::*;

    logic [31:0] mstatus, mcause;
    logic [31:0] newVal;

    always_comb begin
        case (addr)
            `RV_CSR_MSTATUS: oldVal = mstatus;
            `RV_CSR_MTVEC:   oldVal = mtvec;
            `RV_CSR_MEPC:    oldVal = mepc;
            `RV_CSR_MCAUSE:  oldVal = mcause;
            default:         oldVal = 32'b0;
        endcase
        case (op)
            CSR_RS:  newVal = oldVal | wval;
            CSR_RC:  newVal = oldVal & ~wval;
            default: newVal = wval;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= 32'b0;
            mtvec <= 32'b0;
            mepc <= 32'b0;
            mcause <= 32'b0;
        end else if (trap) begin
            mepc <= trapPc;
            mcause <= `RV_CAUSE_ECALL;
            mstatus[`RV_MSTATUS_MPIE] <= mstatus[`RV_MSTATUS_MIE];
            mstatus[`RV_MSTATUS_MIE] <= 1'b0;
        end else if (op != CSR_NONE) begin
            case (addr)
                `RV_CSR_MSTATUS: mstatus <= newVal;
                `RV_CSR_MTVEC:   mtvec <= {newVal[31:2], 2'b00}; // direct mode only
                `RV_CSR_MEPC:    mepc <= {newVal[31:2], 2'b00};
                `RV_CSR_MCAUSE:  mcause <= newVal;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pcUnit.sv ====
`default_nettype none
`include "rv_settings.svh"

module pcUnit (
    input  logic        clk,
    input  logic        rst,
    input  rvPkg::pcSel sel,
    input  logic [31:0] branchTarget,
    input  logic [31:0] jalrTarget,
    input  logic [31:0] mtvec,
    input  logic [31:0] mepc,
    input  logic        stop,
    output logic [31:0] pc,
    output logic [31:0] pcPlus4,
    output logic        halted
);
    import rvPkg::*;

    logic [31:0] nextPc;

    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (sel)
            PC_BRANCH, PC_JAL: nextPc = branchTarget;
            PC_JALR:           nextPc = jalrTarget;
            PC_TRAP:           nextPc = mtvec;
            PC_MRET:           nextPc = mepc;
            default:           nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
            halted <= 1'b0;
        end else if (!halted) begin
            if (stop)
                halted <= 1'b1; // pc stays on the stopping instruction
            else
                pc <= nextPc;
        end
    end

    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

`default_nettype wire

// ==== rtl/rvCore.sv ====
`default_nettype none

module rvCore (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] imemAddr,
    input  logic [31:0] imemData,
    output logic [31:0] dmemAddr,
    output logic [31:0] dmemWdata,
    output logic [3:0]  dmemWstrb,
    output logic        dmemRead,
    input  logic [31:0] dmemRdata,
    output logic        halted,
    output logic        illegal
);
    import rvPkg::*;

    logic [4:0]  rs1, rs2, rd;
    logic [31:0] imm, rdata1, rdata2, aluResult, loadData, wbData;
    logic [31:0] pc, pcPlus4, csrOld, mtvec, mepc;
    logic [2:0]  wbSel;
    logic        aluSrcImm, aluSrcPc, regWrite, memWrite, memRead, csrUseImm;
    logic        isBranch, isJal, isJalr, isEcall, isMret, isEbreak, taken;
    logic [11:0] csrAddr;
    aluOp        aluSel;
    memLen       lenSel;
    csrOp        csrCmd;
    pcSel        nextSel;

    assign imemAddr = pc;
    assign dmemAddr = aluResult;
    assign dmemRead = memRead & ~halted;

    pcUnit pcu (
        .clk, .rst, .sel(nextSel),
        .branchTarget(pc + imm), .jalrTarget({aluResult[31:1], 1'b0}),
        .mtvec, .mepc, .stop(isEbreak | illegal),
        .pc, .pcPlus4, .halted
    );

    instrDecode dec (
        .instr(imemData), .rs1, .rs2, .rd, .imm, .aluOp(aluSel),
        .aluSrcImm, .aluSrcPc, .regWrite, .wbSel, .memWrite, .memRead,
        .memLen(lenSel), .csrOp(csrCmd), .csrUseImm, .csrAddr,
        .isBranch, .isJal, .isJalr, .isEcall, .isMret, .isEbreak, .isIllegal(illegal)
    );

    regFile rf (
        .clk, .rs1, .rs2, .rd, .wdata(wbData), .we(regWrite & ~halted), .rdata1, .rdata2
    );

    alu ex (
        .op(aluSel), .a(aluSrcPc ? pc : rdata1), .b(aluSrcImm ? imm : rdata2),
        .funct3(imemData[14:12]), .result(aluResult), .branchTaken(taken)
    );

    lsUnit ls (
        .len(lenSel), .addrLow(aluResult[1:0]), .storeEn(memWrite & ~halted),
        .loadEn(memRead & ~halted), .storeData(rdata2), .rawLoad(dmemRdata),
        .wstrb(dmemWstrb), .wdata(dmemWdata), .loadData
    );

    csrFile csr (
        .clk, .rst, .op(halted ? CSR_NONE : csrCmd), .addr(csrAddr),
        .wval(csrUseImm ? imm : rdata1), .trap(isEcall & ~halted), .trapPc(pc),
        .oldVal(csrOld), .mtvec, .mepc
    );

    // next pc source from the decoded flow flags
    assign nextSel = isEcall ? PC_TRAP :
                     isMret ? PC_MRET :
                     isJal ? PC_JAL :
                     isJalr ? PC_JALR :
                     (isBranch && taken) ? PC_BRANCH : PC_SEQ;

    always_comb begin
        case (wbSel)
            WB_LOAD: wbData = loadData;
            WB_PC4:  wbData = pcPlus4;
            WB_CSR:  wbData = csrOld;
            WB_IMM:  wbData = imm;   // lui
            default: wbData = aluResult;
        endcase
    end

endmodule

`default_nettype wire

// ==== sim/tbRvCore.sv ====
`default_nettype none
`include "rv_settings.svh"

module tbRvCore;
    timeunit 1ns;
    timeprecision 100ps;

    import rvPkg::*;

    localparam logic [31:0] poisonWord = 32'hDEAD_BEEF;
    localparam logic [31:0] ecallWord  = 32'h0000_0073;
    localparam logic [31:0] ebreakWord = 32'h0010_0073;
    localparam logic [31:0] mretWord   = 32'h3020_0073;
    localparam logic [31:0] dataBase   = 32'h0000_0100;

    logic        clk, rst;
    logic [31:0] imemAddr, imemData, dmemAddr, dmemWdata, dmemRdata;
    logic [3:0]  dmemWstrb;
    logic        dmemRead, halted, illegal;

    logic [31:0] prog [512];
    int          progLen;
    logic [7:0]  dmem [1024];
    logic [7:0]  shadowMem [1024]; // model of dmem contents
    logic [31:0] modelReg [32];
    logic [31:0] expAddr [$];
    logic [3:0]  expStrb [$];
    logic [31:0] expData [$];
    int          seed = 94;
    int          slot;            // next free store offset
    int          cycles, cycleLimit, haltCycles;
    logic [31:0] handlerPc, ecallPc, expPc, haltPc;
    logic        pcCheck, haltDue, wasHalted;

    rvCore UUT (
        .clk, .rst, .imemAddr, .imemData, .dmemAddr, .dmemWdata, .dmemWstrb,
        .dmemRead, .dmemRdata, .halted, .illegal
    );

    // same-cycle memories
    assign imemData = (int'(imemAddr[31:2]) < progLen) ? prog[imemAddr[10:2]] : ebreakWord;
    assign dmemRdata = {dmem[{dmemAddr[9:2], 2'd3}], dmem[{dmemAddr[9:2], 2'd2}],
                        dmem[{dmemAddr[9:2], 2'd1}], dmem[{dmemAddr[9:2], 2'd0}]};

    always @(posedge clk) begin
        for (int i = 0; i < 4; i++)
            if (dmemWstrb[i])
                dmem[{dmemAddr[9:2], 2'(i)}] <= dmemWdata[8*i +: 8];
    end

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        instrWord w;
        w.rType.funct7 = f7;
        w.rType.rs2 = rs2;
        w.rType.rs1 = rs1;
        w.rType.funct3 = f3;
        w.rType.rd = rd;
        w.rType.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                         logic [4:0] rd, logic [6:0] opc);
        return encR(imm[11:5], imm[4:0], rs1, f3, rd, opc);
    endfunction

    function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return encR(imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE);
    endfunction

    function automatic logic [31:0] encB(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                         logic [2:0] f3);
        return encR({off[12], off[10:5]}, rs2, rs1, f3, {off[4:1], off[11]}, OPC_BRANCH);
    endfunction

    function automatic logic [31:0] encU(logic [19:0] upper, logic [4:0] rd, logic [6:0] opc);
        instrWord w;
        w.immType.upper = upper;
        w.immType.rd = rd;
        w.immType.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] off, logic [4:0] rd);
        return encU({off[20], off[10:1], off[11], off[19:12]}, rd, OPC_JAL);
    endfunction

    // reference integer semantics
    function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic brRef(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] laneMask(logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    // byte lanes covered by an access of the given size
    function automatic logic [3:0] laneStrobe(logic [1:0] low, int bytes);
        logic [3:0] s;
        s = 4'b0;
        for (int i = 0; i < bytes; i++)
            s[low + i] = 1'b1;
        return s;
    endfunction

    function automatic logic [31:0] pcNow();
        return 32'(progLen * 4);
    endfunction

    task automatic emit(logic [31:0] w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic setReg(logic [4:0] rd, logic [31:0] v);
        if (rd != 5'd0)
            modelReg[rd] = v;
    endtask

    task automatic expectStore(int off, logic [3:0] strb, logic [31:0] data);
        logic [31:0] addr;
        addr = dataBase + 32'(off);
        expAddr.push_back(addr);
        expStrb.push_back(strb);
        expData.push_back(data);
        for (int i = 0; i < 4; i++)
            if (strb[i])
                shadowMem[{addr[9:2], 2'(i)}] = data[8*i +: 8];
    endtask

    task automatic loadConst(logic [4:0] rd, logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        emit(encU(hi[31:12], rd, OPC_LUI));
        emit(encI(v[11:0], rd, 3'b000, rd, OPC_OPIMM));
        setReg(rd, v);
    endtask

    task automatic storeNext(logic [4:0] rs);
        emit(encS(12'(slot), rs, 5'd1, 3'b010));
        expectStore(slot, 4'hF, modelReg[rs]);
        slot += 4;
    endtask

    task automatic storeNarrow(logic [4:0] rs, int off, logic half);
        logic [1:0]  low;
        logic [31:0] v;
        low = 2'(off);
        v = half ? {16'b0, modelReg[rs][15:0]} : {24'b0, modelReg[rs][7:0]};
        emit(encS(12'(off), rs, 5'd1, half ? 3'b001 : 3'b000));
        expectStore(off, laneStrobe(low, half ? 2 : 1), v << (8 * low));
    endtask

    task automatic loadFrom(logic [2:0] f3, logic [4:0] rd, int off);
        logic [9:0]  a;
        logic [15:0] h;
        a = 10'(32'(off) + dataBase);
        h = {shadowMem[a + 10'd1], shadowMem[a]};
        emit(encI(12'(off), 5'd1, f3, rd, OPC_LOAD));
        case (f3)
            3'b000: setReg(rd, {{24{h[7]}}, h[7:0]});
            3'b100: setReg(rd, {24'b0, h[7:0]});
            3'b001: setReg(rd, {{16{h[15]}}, h});
            3'b101: setReg(rd, {16'b0, h});
            default: setReg(rd, {shadowMem[a + 10'd3], shadowMem[a + 10'd2], h});
        endcase
    endtask

    // a wrongly resolved branch lands on the poison store
    task automatic branchCase(logic [2:0] f3, logic [4:0] ra, logic [4:0] rb);
        emit(encB(13'd8, rb, ra, f3));
        if (!brRef(f3, modelReg[ra], modelReg[rb]))
            emit(encJ(21'd8, 5'd0));
        emit(encS(12'h3F0, 5'd9, 5'd1, 3'b010));
    endtask

    task automatic buildProgram();
        logic [11:0] immv;
        logic [19:0] up;
        logic [2:0]  f3s [6];
        logic [31:0] link;
        f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        progLen = 0;
        slot = 0;
        for (int i = 0; i < 32; i++)
            modelReg[i] = 32'b0;
        for (int i = 0; i < 1024; i++) begin
            shadowMem[i] = 8'(i + (i >> 8) * 59);
            dmem[i] <= shadowMem[i];
        end
        loadConst(5'd1, dataBase);
        loadConst(5'd2, $random(seed));
        loadConst(5'd3, $random(seed));
        for (int f = 0; f < 10; f++) begin // eight plain ops, then sub and sra
            emit(encR(f > 7 ? 7'h20 : 7'h00, 5'd3, 5'd2, f > 7 ? 3'(5 * (f - 8)) : 3'(f),
                      5'd4, OPC_OP));
            setReg(5'd4, aluRef(f > 7 ? 3'(5 * (f - 8)) : 3'(f), f > 7, modelReg[2],
                                modelReg[3]));
            storeNext(5'd4);
        end
        for (int f = 0; f < 9; f++) begin
            immv = 12'($random(seed));
            if (f == 1 || f == 5)
                immv = {7'h00, immv[4:0]};
            else if (f == 8)
                immv = {7'h20, immv[4:0]};
            emit(encI(immv, 5'd2, f == 8 ? 3'd5 : 3'(f), 5'd4, OPC_OPIMM));
            setReg(5'd4, aluRef(f == 8 ? 3'd5 : 3'(f), f == 8, modelReg[2],
                                f == 8 ? {27'b0, immv[4:0]} : {{20{immv[11]}}, immv}));
            storeNext(5'd4);
        end
        up = 20'($random(seed));
        emit(encU(up, 5'd4, OPC_LUI));
        setReg(5'd4, {up, 12'b0});
        storeNext(5'd4);
        setReg(5'd4, pcNow() + {up, 12'b0});
        emit(encU(up, 5'd4, OPC_AUIPC));
        storeNext(5'd4);

        // byte and half stores at every legal offset, then read back
        loadConst(5'd5, $random(seed));
        storeNarrow(5'd2, slot, 1'b0);
        storeNarrow(5'd3, slot + 1, 1'b0);
        storeNarrow(5'd4, slot + 2, 1'b0);
        storeNarrow(5'd5, slot + 3, 1'b0);
        storeNarrow(5'd2, slot + 4, 1'b1);
        storeNarrow(5'd3, slot + 6, 1'b1);
        loadFrom(3'b010, 5'd6, slot);
        slot += 8;
        storeNext(5'd6);
        loadFrom(3'b010, 5'd6, slot - 8 + 4);
        storeNext(5'd6);

        // every byte has its top bit set
        loadConst(5'd7, 32'h9A85_F3C1);
        storeNext(5'd7);
        loadFrom(3'b000, 5'd8, slot - 4 + 1);
        storeNext(5'd8);
        loadFrom(3'b100, 5'd8, slot - 8 + 3);
        storeNext(5'd8);
        loadFrom(3'b001, 5'd8, slot - 12 + 2);
        storeNext(5'd8);
        loadFrom(3'b101, 5'd8, slot - 16);
        storeNext(5'd8);

        loadConst(5'd9, poisonWord);
        loadConst(5'd12, 32'hFFFF_FFFB);
        loadConst(5'd13, 32'd3);
        foreach (f3s[k]) begin
            branchCase(f3s[k], 5'd12, 5'd13);
            branchCase(f3s[k], 5'd13, 5'd12);
            branchCase(f3s[k], 5'd12, 5'd12);
        end
        link = pcNow() + 32'd4;
        emit(encJ(21'd8, 5'd14));
        setReg(5'd14, link);
        emit(encS(12'h3F0, 5'd9, 5'd1, 3'b010));
        storeNext(5'd14);
        emit(encI(12'(pcNow() + 32'd12), 5'd0, 3'b000, 5'd15, OPC_OPIMM));
        link = pcNow() + 32'd4;
        emit(encI(12'd0, 5'd15, 3'b000, 5'd16, OPC_JALR));
        setReg(5'd16, link);
        emit(encS(12'h3F0, 5'd9, 5'd1, 3'b010));
        storeNext(5'd16);

        handlerPc = pcNow() + 32'd16;
        ecallPc = pcNow() + 32'd8;
        emit(encI(handlerPc[11:0], 5'd0, 3'b000, 5'd17, OPC_OPIMM));
        emit(encI(`RV_CSR_MTVEC, 5'd17, 3'b001, 5'd0, OPC_SYSTEM));
        emit(ecallWord);
        emit(ebreakWord);
        emit(encI(`RV_CSR_MCAUSE, 5'd0, 3'b010, 5'd18, OPC_SYSTEM));
        setReg(5'd18, `RV_CAUSE_ECALL);
        storeNext(5'd18);
        emit(encI(`RV_CSR_MEPC, 5'd0, 3'b010, 5'd19, OPC_SYSTEM));
        setReg(5'd19, ecallPc);
        storeNext(5'd19);
        emit(encI(12'd4, 5'd19, 3'b000, 5'd19, OPC_OPIMM));
        emit(encI(`RV_CSR_MEPC, 5'd19, 3'b001, 5'd0, OPC_SYSTEM));
        emit(mretWord);
    endtask

    task automatic mismatch(string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic abortRun(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        buildProgram();
        cycleLimit = 5 * progLen + 20;
        repeat (10) @(posedge clk);
        #5 rst = 1'b0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit)
            abortRun($sformatf("timeout after %0d cycles without halting", cycles));
    end

    // outputs are sampled mid-cycle where they are settled
    always @(negedge clk) begin
        logic [31:0] mask;
        if (!rst) begin
            assert (!illegal) else mismatch($sformatf("illegal raised at pc %h", imemAddr));
            assert (dmemRead == (imemData[6:0] == OPC_LOAD))
                else mismatch($sformatf("dmemRead %b at pc %h", dmemRead, imemAddr));
            if (pcCheck) begin
                assert (imemAddr == expPc)
                    else mismatch($sformatf("pc %h, expected %h", imemAddr, expPc));
                pcCheck = 1'b0;
            end
            if (dmemWstrb != 4'b0) begin
                if (expAddr.size() == 0)
                    abortRun("a store happened when none was expected");
                mask = laneMask(expStrb[0]);
                assert (dmemWdata != poisonWord)
                    else mismatch($sformatf("poison store at %h", dmemAddr));
                assert (dmemAddr == expAddr[0] && dmemWstrb == expStrb[0]
                        && (dmemWdata & mask) == (expData[0] & mask))
                    else mismatch($sformatf("store %h/%b/%h, expected %h/%b/%h",
                        dmemAddr, dmemWstrb, dmemWdata, expAddr[0], expStrb[0], expData[0]));
                void'(expAddr.pop_front());
                void'(expStrb.pop_front());
                void'(expData.pop_front());
            end
            if (halted) begin
                if (!wasHalted) begin
                    if (!haltDue)
                        abortRun("the core halted without an EBREAK");
                    if (expAddr.size() != 0)
                        abortRun("the core halted before all expected stores");
                    haltPc = imemAddr;
                    wasHalted = 1'b1;
                end
                assert (imemAddr == haltPc) else mismatch("pc moved after halt");
                assert (dmemWstrb == 4'b0) else mismatch("store strobe after halt");
                haltCycles++;
                if (haltCycles == 4) begin
                    $display("test passed");
                    $finish;
                end
            end else begin
                if (wasHalted)
                    abortRun("halted fell before reset");
                if (haltDue)
                    abortRun("halted did not rise after EBREAK");
                haltDue = (imemData == ebreakWord);
                if (imemData == ecallWord) begin
                    pcCheck = 1'b1;
                    expPc = handlerPc;
                end
                if (imemData == mretWord) begin
                    pcCheck = 1'b1;
                    expPc = ecallPc + 32'd4; // mepc as rewritten by the handler
                end
            end
        end
    end

    initial begin
        cycles = 0;
        haltCycles = 0;
        pcCheck = 1'b1; // first fetch comes from the reset vector
        expPc = `RV_RESET_PC;
        haltDue = 1'b0;
        wasHalted = 1'b0;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+rtl
rtl/rvPkg.sv
rtl/instrDecode.sv
rtl/regFile.sv
rtl/alu.sv
rtl/lsUnit.sv
rtl/csrFile.sv
rtl/pcUnit.sv
rtl/rvCore.sv
sim/tbRvCore.sv

// ==== build.sh ====
#!/usr/bin/env bash
# compile the core and testbench, then run; exit status follows the simulation
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f all.f --top-module tbRvCore -o simRv \
    && ./obj_dir/simRv \
    || exit 1
